/* design/fetch_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_queue import rv_frontend_pkg::*; #(
    parameter int FQ_DEPTH = 4
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          flush,
    input  logic          in_valid,
    output logic          in_ready,
    input  fetch_packet_t in_packet,
    output logic          out_valid,
    input  logic          out_ready,
    output fetch_packet_t out_packet
);
    localparam int PTR_W = (FQ_DEPTH > 1) ? $clog2(FQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(FQ_DEPTH + 1);

    fetch_packet_t    entries [FQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FQ_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full = (count == CNT_W'(FQ_DEPTH));

    // Full queue still takes a packet when the head leaves
    assign in_ready   = !flush && (!full || out_ready);
    assign out_valid  = (count != '0);
    assign out_packet = entries[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= in_packet;
        end
    end

endmodule

`default_nettype wire

/* design/instruction_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module instruction_decode import rv_frontend_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          flush,
    input  logic          fq_valid,
    input  fetch_packet_t fq_packet,
    output logic          fq_ready,
    output logic          id_valid,
    output id_ix_t        id_ix,
    input  logic          id_ready
);
    instr_u     instr;
    logic [2:0] funct3;
    logic [6:0] funct7;
    imm_type_e  imm_src;
    id_ix_t     dec;

    function automatic logic [31:0] select_imm(input instr_u ins, input imm_type_e kind);
        logic [31:0] imm;
        case (kind)
            IMM_TYPE_I: begin
                imm = {{20{ins.i.imm[11]}}, ins.i.imm};
            end
            IMM_TYPE_S: begin
                imm = {{20{ins.s.imm_11_5[6]}}, ins.s.imm_11_5, ins.s.imm_4_0};
            end
            IMM_TYPE_B: begin
                imm = {{19{ins.b.imm_12}}, ins.b.imm_12, ins.b.imm_11,
                       ins.b.imm_10_5, ins.b.imm_4_1, 1'b0};
            end
            IMM_TYPE_J: begin
                imm = {{11{ins.j.imm_20}}, ins.j.imm_20, ins.j.imm_19_12,
                       ins.j.imm_11, ins.j.imm_10_1, 1'b0};
            end
            // Shift amount sits in the rs2 slot
            IMM_TYPE_SH: begin
                imm = {27'b0, ins.r.rs2};
            end
            default: begin
                imm = {ins.u.imm_31_12, 12'b0};
            end
        endcase
        return imm;
    endfunction

    assign instr  = fq_packet.instr;
    assign funct3 = instr.r.funct3;
    assign funct7 = instr.r.funct7;

    // Main decoder
    always_comb begin
        dec          = '0;
        dec.a1       = instr.r.rs1;
        dec.a2       = instr.r.rs2;
        dec.rd       = instr.r.rd;
        dec.pc       = fq_packet.pc;
        dec.pc_inc   = fq_packet.pc_inc;
        dec.btp_info = fq_packet.btp_info;

        dec.alu_control = ALU_OP_ADD;
        dec.mul_control = MUL_OP_MUL;
        dec.div_control = DIV_OP_DIV;
        dec.lsu_control = funct3;
        dec.branch_op   = branch_op_e'(funct3);
        dec.exe_pipe    = EXE_PIPE_INVALID;
        imm_src         = IMM_TYPE_I;

        case (instr.r.opcode)
            INSTR_OPCODE_ALU_MUL_DIV_R: begin
                dec.register_write = 1'b1;
                dec.alu_control    = alu_op_e'({funct7[5], funct3});
                dec.mul_control    = mul_op_e'(funct3[1:0]);
                dec.div_control    = div_op_e'(funct3[1:0]);
                // M extension when funct7[0], divides have funct3[2]
                if (!funct7[0]) begin
                    dec.exe_pipe = EXE_PIPE_ALU;
                end else if (funct3[2]) begin
                    dec.exe_pipe = EXE_PIPE_DIV;
                end else begin
                    dec.exe_pipe = EXE_PIPE_MUL;
                end
            end
            INSTR_OPCODE_LSU_LOAD: begin
                dec.mem_load       = 1'b1;
                dec.alu_src        = 1'b1;
                dec.register_write = 1'b1;
                dec.a2             = '0;
                dec.exe_pipe       = EXE_PIPE_LSU;
            end
            INSTR_OPCODE_LSU_STORE: begin
                dec.mem_store = 1'b1;
                dec.alu_src   = 1'b1;
                dec.rd        = '0;
                dec.exe_pipe  = EXE_PIPE_LSU;
                imm_src       = IMM_TYPE_S;
            end
            INSTR_OPCODE_ALU_BRANCH: begin
                dec.branch   = 1'b1;
                dec.rd       = '0;
                dec.exe_pipe = EXE_PIPE_ALU;
                imm_src      = IMM_TYPE_B;
            end
            INSTR_OPCODE_ALU_I: begin
                // Only SRAI carries funct7[5]
                dec.alu_control    = alu_op_e'({(funct3 == FUNCT3_SRL_SRA) && funct7[5],
                                                funct3});
                dec.alu_src        = 1'b1;
                dec.register_write = 1'b1;
                dec.a2             = '0;
                dec.exe_pipe       = EXE_PIPE_ALU;
                if ((funct3 == FUNCT3_SLL) || (funct3 == FUNCT3_SRL_SRA)) begin
                    imm_src = IMM_TYPE_SH;
                end
            end
            INSTR_OPCODE_ALU_JALR: begin
                dec.jalr           = 1'b1;
                dec.result_src     = 1'b1;
                dec.alu_src        = 1'b1;
                dec.register_write = 1'b1;
                dec.a2             = '0;
                dec.exe_pipe       = EXE_PIPE_ALU;
            end
            INSTR_OPCODE_ALU_JAL: begin
                dec.jal            = 1'b1;
                dec.result_src     = 1'b1;
                dec.register_write = 1'b1;
                dec.a1             = '0;
                dec.a2             = '0;
                dec.exe_pipe       = EXE_PIPE_ALU;
                imm_src            = IMM_TYPE_J;
            end
            INSTR_OPCODE_ALU_LUI, INSTR_OPCODE_ALU_AUIPC: begin
                dec.register_write = 1'b1;
                dec.alu_control    = (instr.u.opcode == INSTR_OPCODE_ALU_LUI) ?
                                     ALU_OP_LUI : ALU_OP_AUIPC;
                dec.a1             = '0;
                dec.a2             = '0;
                dec.exe_pipe       = EXE_PIPE_ALU;
                imm_src            = IMM_TYPE_U;
            end
            INSTR_OPCODE_FENCE: begin
                // Plain fence has nothing to do in order
                dec.icache_invalidate = (funct3 == FUNCT3_FENCE_I);
                dec.a1                = '0;
                dec.a2                = '0;
                dec.rd                = '0;
                dec.exe_pipe          = dec.icache_invalidate ? EXE_PIPE_ALU : EXE_PIPE_INVALID;
            end
            INSTR_OPCODE_CSR: begin
                dec.dcache_flush = (funct3 == CSR_OP_RW) && (instr.i.imm == CSR_REG_DCACHE_FLUSH);
                dec.a1           = '0;
                dec.a2           = '0;
                dec.rd           = '0;
                dec.exe_pipe     = dec.dcache_flush ? EXE_PIPE_LSU : EXE_PIPE_INVALID;
            end
            default: begin
            end
        endcase

        // x0 is never written
        dec.register_write = dec.register_write && (dec.rd != '0);
        dec.imm_ext        = select_imm(instr, imm_src);
    end

    // Hold the bundle while the router is busy
    assign fq_ready = !id_valid || id_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
        end else if (flush) begin
            id_valid <= 1'b0;
        end else if (fq_ready) begin
            id_valid <= fq_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fq_valid && fq_ready) begin
            id_ix <= dec;
        end
    end

endmodule

`default_nettype wire

/* design/issue_router.sv */
`timescale 1ns/100ps
`default_nettype none

module issue_router import rv_frontend_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,
    input  logic       id_valid,
    input  id_ix_t     id_ix,
    output logic       id_ready,
    output logic [3:0] pipe_valid,
    input  logic [3:0] pipe_ready,
    output id_ix_t     issue
);
    id_ix_t slot;
    id_ix_t skid;
    logic   slot_valid;
    logic   skid_valid;
    logic   accept;
    logic   fire;
    logic   slot_free;

    // Registered ready, the skid absorbs the cycle after a stall
    assign id_ready = !skid_valid;

    // Bundles without a pipe vanish here
    assign accept = id_valid && id_ready && (id_ix.exe_pipe != EXE_PIPE_INVALID);

    assign pipe_valid = slot_valid ? slot.exe_pipe : 4'b0000;
    assign fire       = |(pipe_valid & pipe_ready);
    assign slot_free  = !slot_valid || fire;
    assign issue      = slot;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (flush) begin
            slot_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (slot_free) begin
            slot_valid <= skid_valid || accept;
            skid_valid <= 1'b0;
        end else if (accept) begin
            skid_valid <= 1'b1;
        end
    end

    // Skid entry goes first to keep program order
    always_ff @(posedge clk) begin
        if (slot_free) begin
            if (skid_valid) begin
                slot <= skid;
            end else if (accept) begin
                slot <= id_ix;
            end
        end else if (accept) begin
            skid <= id_ix;
        end
    end

endmodule

`default_nettype wire

/* design/rv_frontend.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_frontend import rv_frontend_pkg::*; #(
    parameter int FQ_DEPTH = 4
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          flush,
    input  logic          fetch_valid,
    output logic          fetch_ready,
    input  fetch_packet_t fetch,
    output logic [3:0]    pipe_valid,
    input  logic [3:0]    pipe_ready,
    output id_ix_t        issue
);
    logic          fq_valid;
    logic          fq_ready;
    fetch_packet_t fq_packet;
    logic          id_valid;
    logic          id_ready;
    id_ix_t        id_ix;

    fetch_queue #(
        .FQ_DEPTH (FQ_DEPTH)
    ) i_fetch_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .in_valid   (fetch_valid),
        .in_ready   (fetch_ready),
        .in_packet  (fetch),
        .out_valid  (fq_valid),
        .out_ready  (fq_ready),
        .out_packet (fq_packet)
    );

    instruction_decode i_instruction_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .fq_valid  (fq_valid),
        .fq_packet (fq_packet),
        .fq_ready  (fq_ready),
        .id_valid  (id_valid),
        .id_ix     (id_ix),
        .id_ready  (id_ready)
    );

    issue_router i_issue_router (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .id_valid   (id_valid),
        .id_ix      (id_ix),
        .id_ready   (id_ready),
        .pipe_valid (pipe_valid),
        .pipe_ready (pipe_ready),
        .issue      (issue)
    );

endmodule

`default_nettype wire

/* design/rv_frontend_pkg.sv */
`default_nettype none

package rv_frontend_pkg;

`include "rv_isa.svh"

    // Instruction formats, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    // funct7[5] then funct3, LUI and AUIPC use free codes
    typedef enum logic [3:0] {
        ALU_OP_ADD   = 4'b0000,
        ALU_OP_SLL   = 4'b0001,
        ALU_OP_SLT   = 4'b0010,
        ALU_OP_SLTU  = 4'b0011,
        ALU_OP_XOR   = 4'b0100,
        ALU_OP_SRL   = 4'b0101,
        ALU_OP_OR    = 4'b0110,
        ALU_OP_AND   = 4'b0111,
        ALU_OP_SUB   = 4'b1000,
        ALU_OP_LUI   = 4'b1010,
        ALU_OP_AUIPC = 4'b1011,
        ALU_OP_SRA   = 4'b1101
    } alu_op_e;

    typedef enum logic [1:0] {
        MUL_OP_MUL    = 2'b00,
        MUL_OP_MULH   = 2'b01,
        MUL_OP_MULHSU = 2'b10,
        MUL_OP_MULHU  = 2'b11
    } mul_op_e;

    typedef enum logic [1:0] {
        DIV_OP_DIV  = 2'b00,
        DIV_OP_DIVU = 2'b01,
        DIV_OP_REM  = 2'b10,
        DIV_OP_REMU = 2'b11
    } div_op_e;

    typedef enum logic [2:0] {
        BRANCH_OP_BEQ  = 3'b000,
        BRANCH_OP_BNE  = 3'b001,
        BRANCH_OP_BLT  = 3'b100,
        BRANCH_OP_BGE  = 3'b101,
        BRANCH_OP_BLTU = 3'b110,
        BRANCH_OP_BGEU = 3'b111
    } branch_op_e;

    typedef enum logic [2:0] {
        IMM_TYPE_I,
        IMM_TYPE_S,
        IMM_TYPE_B,
        IMM_TYPE_J,
        IMM_TYPE_U,
        IMM_TYPE_SH
    } imm_type_e;

    // One-hot, bit 0 is ALU
    typedef enum logic [3:0] {
        EXE_PIPE_INVALID = 4'b0000,
        EXE_PIPE_ALU     = 4'b0001,
        EXE_PIPE_MUL     = 4'b0010,
        EXE_PIPE_DIV     = 4'b0100,
        EXE_PIPE_LSU     = 4'b1000
    } exe_pipe_e;

    typedef struct packed {
        logic        taken;
        logic [29:0] target;
    } btp_info_t;

    typedef struct packed {
        instr_u      instr;
        logic [31:0] pc;
        logic [31:0] pc_inc;
        btp_info_t   btp_info;
    } fetch_packet_t;

    typedef struct packed {
        logic [4:0]  a1;
        logic [4:0]  a2;
        logic [4:0]  rd;
        logic [31:0] imm_ext;
        logic [31:0] pc;
        logic [31:0] pc_inc;
        btp_info_t   btp_info;
        logic        register_write;
        logic        branch;
        logic        jal;
        logic        jalr;
        branch_op_e  branch_op;
        logic        result_src;
        logic        mem_load;
        logic        mem_store;
        logic        icache_invalidate;
        logic        dcache_flush;
        alu_op_e     alu_control;
        mul_op_e     mul_control;
        div_op_e     div_control;
        logic [2:0]  lsu_control;
        logic        alu_src;
        exe_pipe_e   exe_pipe;
    } id_ix_t;

endpackage

`default_nettype wire

/* include/rv_isa.svh */
`ifndef RV_ISA_SVH
`define RV_ISA_SVH

// RV32IM major opcodes
localparam logic [6:0] INSTR_OPCODE_ALU_MUL_DIV_R = 7'b0110011;
localparam logic [6:0] INSTR_OPCODE_LSU_LOAD      = 7'b0000011;
localparam logic [6:0] INSTR_OPCODE_LSU_STORE     = 7'b0100011;
localparam logic [6:0] INSTR_OPCODE_ALU_BRANCH    = 7'b1100011;
localparam logic [6:0] INSTR_OPCODE_ALU_I         = 7'b0010011;
localparam logic [6:0] INSTR_OPCODE_ALU_JALR      = 7'b1100111;
localparam logic [6:0] INSTR_OPCODE_ALU_JAL       = 7'b1101111;
localparam logic [6:0] INSTR_OPCODE_ALU_LUI       = 7'b0110111;
localparam logic [6:0] INSTR_OPCODE_ALU_AUIPC     = 7'b0010111;
localparam logic [6:0] INSTR_OPCODE_FENCE         = 7'b0001111;
localparam logic [6:0] INSTR_OPCODE_CSR           = 7'b1110011;

// funct3 values that change decoding
localparam logic [2:0] FUNCT3_FENCE_I = 3'b001;
localparam logic [2:0] FUNCT3_SLL     = 3'b001;
localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
localparam logic [2:0] CSR_OP_RW      = 3'b001;

// Custom machine CSR, a write to it requests a D$ flush
localparam logic [11:0] CSR_REG_DCACHE_FLUSH = 12'h7c0;

`endif

/* rv_frontend.f */
+incdir+include
design/rv_frontend_pkg.sv
design/fetch_queue.sv
design/instruction_decode.sv
design/issue_router.sv
design/rv_frontend.sv
verification/rv_frontend_checker.sv
verification/rv_frontend_tb.sv

/* verification/rv_frontend_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_frontend_checker import rv_frontend_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,
    input  logic       fetch_ready,
    input  logic [3:0] pipe_valid,
    input  logic [3:0] pipe_ready,
    input  id_ix_t     issue
);
    int assertion_failures = 0;

    a_pipe_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(pipe_valid))
    else begin
        $error("pipe_valid has more than one bit set");
        assertion_failures++;
    end

    // A stalled issue keeps its bundle and its pipe
    a_issue_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ((|pipe_valid) && !(|(pipe_valid & pipe_ready)) && !flush)
        |=> ($stable(issue) && $stable(pipe_valid)))
    else begin
        $error("issue bundle changed while stalled");
        assertion_failures++;
    end

    a_flush_blocks_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        flush |-> !fetch_ready)
    else begin
        $error("fetch_ready high during flush");
        assertion_failures++;
    end

    a_flush_clears_issue: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> (pipe_valid == 4'b0000))
    else begin
        $error("pipe_valid high in the cycle after flush");
        assertion_failures++;
    end

endmodule

bind rv_frontend rv_frontend_checker i_rv_frontend_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .fetch_ready (fetch_ready),
    .pipe_valid  (pipe_valid),
    .pipe_ready  (pipe_ready),
    .issue       (issue)
);

`default_nettype wire

/* verification/rv_frontend_stimulus.txt */
// kind instr pc btp ops(pipe a1 a2 rd) imm_ext ctrl(wr alu mul div ld st fi fd)
// kind 0 instruction, 1 pipe mode in col 2, 2 flush over the next N lines, f end
0 002081B3 00001000 0 01010203 00000002 10000000
0 407302B3 00001004 0 01060705 00000407 18000000
0 40C5D533 00001008 0 010B0C0A 0000040C 1D000000
0 003130B3 0000100C 0 01020301 00000003 13000000
0 FFB08213 00001010 0 01010004 FFFFFFFB 10000000
0 7FF44393 00001014 0 01080007 000007FF 14000000
0 00749493 00001018 0 01090009 00000007 11000000
0 41F1D113 0000101C 0 01030002 0000001F 1D000000
0 0011D113 00001020 0 01030002 00000001 15000000
0 123452B7 00001024 0 01000005 12345000 1A000000
0 FFFFF317 00001028 0 01000006 FFFFF000 1B000000
0 FFC12403 0000102C 0 08020008 FFFFFFFC 10001000
0 0091AA23 00001030 0 08030900 00000014 00000100
0 FE120FA3 00001034 0 08040100 FFFFFFFF 00000100
0 00208863 00001038 1 01010200 00000010 00000000
0 FE419CE3 0000103C 0 01030400 FFFFFFF8 00000000
0 001000EF 00001040 1 01000001 00000800 10000000
0 00008067 00001044 0 01010000 00000000 00000000
0 02C58533 00001048 0 020B0C0A 0000002C 10000000
0 02F736B3 0000104C 0 020E0F0D 0000002F 13300000
0 023120B3 00001050 0 02020301 00000023 12200000
0 0262C233 00001054 0 04050604 00000026 14000000
0 029473B3 00001058 0 04080907 00000029 17030000
0 0220D033 0000105C 0 04010200 00000022 05010000
0 00208033 00001060 0 01010200 00000002 00000000
0 0FF0000F 00001064 0 00000000 00000000 00000000
0 30009073 00001068 0 00000000 00000000 00000000
0 FFFFFFFF 0000106C 0 00000000 00000000 00000000
0 0000100F 00001070 0 01000000 00000000 00000010
0 7C029073 00001074 0 08000000 000007C0 00000001
0 7C02A073 00001078 0 00000000 00000000 00000000
1 00000001 00000000 0 00000000 00000000 00000000
0 002081B3 00002000 0 01010203 00000002 10000000
0 02C58533 00002004 0 020B0C0A 0000002C 10000000
0 FFC12403 00002008 0 08020008 FFFFFFFC 10001000
0 0262C233 0000200C 0 04050604 00000026 14000000
0 0FF0000F 00002010 0 00000000 00000000 00000000
0 0091AA23 00002014 0 08030900 00000014 00000100
0 00208863 00002018 1 01010200 00000010 00000000
0 123452B7 0000201C 0 01000005 12345000 1A000000
0 029473B3 00002020 0 04080907 00000029 17030000
0 7C029073 00002024 0 08000000 000007C0 00000001
0 407302B3 00002028 0 01060705 00000407 18000000
1 00000000 00000000 0 00000000 00000000 00000000
2 00000009 00000000 0 00000000 00000000 00000000
0 00108093 00003000 0 01010001 00000001 10000000
0 00108093 00003004 0 01010001 00000001 10000000
0 00108093 00003008 0 01010001 00000001 10000000
0 00108093 0000300C 0 01010001 00000001 10000000
0 00108093 00003010 0 01010001 00000001 10000000
0 00108093 00003014 0 01010001 00000001 10000000
0 00108093 00003018 0 01010001 00000001 10000000
0 00108093 0000301C 0 01010001 00000001 10000000
0 00108093 00003020 0 01010001 00000001 10000000
0 407302B3 00004000 0 01060705 00000407 18000000
0 FFC12403 00004004 0 08020008 FFFFFFFC 10001000
0 02F736B3 00004008 0 020E0F0D 0000002F 13300000
0 001000EF 0000400C 1 01000001 00000800 10000000
f 00000000 00000000 0 00000000 00000000 00000000

/* verification/rv_frontend_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_frontend_tb import rv_frontend_pkg::*;;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int REC_W        = 7;
    localparam int STIM_WORDS   = 1024;
    localparam int FQ_DEPTH     = 4;
    localparam int DRAIN_CYCLES = 100;

    logic          clk;
    logic          rst_n;
    logic          flush;
    logic          fetch_valid;
    logic          fetch_ready;
    fetch_packet_t fetch;
    logic [3:0]    pipe_valid;
    logic [3:0]    pipe_ready;
    id_ix_t        issue;

    logic [31:0] stim [STIM_WORDS];
    id_ix_t      exp_q [$];
    int          rec_count;
    int          pipe_mode;
    bit          random_gaps;
    bit          stim_loaded;
    int          expected_total;
    int          issued_count;

    rv_frontend #(
        .FQ_DEPTH (FQ_DEPTH)
    ) i_rv_frontend (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch       (fetch),
        .pipe_valid  (pipe_valid),
        .pipe_ready  (pipe_ready),
        .issue       (issue)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] act,
                                   input logic [31:0] exp);
        $display("FAILED at %0t: %s is %h, expected %h", $time, name, act, exp);
        stop_with_failure();
    endtask

    task automatic compare_pipe(input exe_pipe_e act, input exe_pipe_e exp);
        if (act !== exp) begin
            $display("FAILED at %0t: pipe_valid is %b, expected %b", $time, act, exp);
            stop_with_failure();
        end
    endtask

    task automatic compare_issue(input id_ix_t act, input id_ix_t exp);
        if (act.a1 !== exp.a1) report_mismatch("issue.a1", act.a1, exp.a1);
        if (act.a2 !== exp.a2) report_mismatch("issue.a2", act.a2, exp.a2);
        if (act.rd !== exp.rd) report_mismatch("issue.rd", act.rd, exp.rd);
        if (act.imm_ext !== exp.imm_ext) begin
            report_mismatch("issue.imm_ext", act.imm_ext, exp.imm_ext);
        end
        if (act.pc !== exp.pc) report_mismatch("issue.pc", act.pc, exp.pc);
        if (act.pc_inc !== exp.pc_inc) report_mismatch("issue.pc_inc", act.pc_inc, exp.pc_inc);
        if (act.btp_info !== exp.btp_info) begin
            report_mismatch("issue.btp_info", act.btp_info, exp.btp_info);
        end
        if (act.register_write !== exp.register_write) begin
            report_mismatch("issue.register_write", act.register_write, exp.register_write);
        end
        if (act.mem_load !== exp.mem_load) begin
            report_mismatch("issue.mem_load", act.mem_load, exp.mem_load);
        end
        if (act.mem_store !== exp.mem_store) begin
            report_mismatch("issue.mem_store", act.mem_store, exp.mem_store);
        end
        if (act.icache_invalidate !== exp.icache_invalidate) begin
            report_mismatch("issue.icache_invalidate", act.icache_invalidate,
                            exp.icache_invalidate);
        end
        if (act.dcache_flush !== exp.dcache_flush) begin
            report_mismatch("issue.dcache_flush", act.dcache_flush, exp.dcache_flush);
        end
        // Operation codes only matter for the pipe that runs them
        if (exp.exe_pipe == EXE_PIPE_ALU && act.alu_control !== exp.alu_control) begin
            report_mismatch("issue.alu_control", act.alu_control, exp.alu_control);
        end
        if (exp.exe_pipe == EXE_PIPE_MUL && act.mul_control !== exp.mul_control) begin
            report_mismatch("issue.mul_control", act.mul_control, exp.mul_control);
        end
        if (exp.exe_pipe == EXE_PIPE_DIV && act.div_control !== exp.div_control) begin
            report_mismatch("issue.div_control", act.div_control, exp.div_control);
        end
    endtask

    function automatic fetch_packet_t build_packet(input int base);
        fetch_packet_t pkt;
        pkt          = '0;
        pkt.instr    = stim[base + 1];
        pkt.pc       = stim[base + 2];
        pkt.pc_inc   = stim[base + 2] + 32'd4;
        pkt.btp_info = {stim[base + 3][0], stim[base + 2][31:2]};
        return pkt;
    endfunction

    // ops word is pipe, a1, a2, rd one byte each
    function automatic id_ix_t build_expected(input int base);
        id_ix_t      e;
        logic [31:0] ops;
        logic [31:0] ctl;
        ops                 = stim[base + 4];
        ctl                 = stim[base + 6];
        e                   = '0;
        e.exe_pipe          = exe_pipe_e'(ops[27:24]);
        e.a1                = ops[20:16];
        e.a2                = ops[12:8];
        e.rd                = ops[4:0];
        e.imm_ext           = stim[base + 5];
        e.pc                = stim[base + 2];
        e.pc_inc            = stim[base + 2] + 32'd4;
        e.btp_info          = {stim[base + 3][0], stim[base + 2][31:2]};
        e.register_write    = ctl[28];
        e.alu_control       = alu_op_e'(ctl[27:24]);
        e.mul_control       = mul_op_e'(ctl[21:20]);
        e.div_control       = div_op_e'(ctl[17:16]);
        e.mem_load          = ctl[12];
        e.mem_store         = ctl[8];
        e.icache_invalidate = ctl[4];
        e.dcache_flush      = ctl[0];
        return e;
    endfunction

    task automatic send_packet(input int base);
        bit accepted;
        accepted = 1'b0;
        @(negedge clk);
        // Idle gaps come before the packet is offered
        while (random_gaps && ($urandom % 3 == 0)) begin
            fetch_valid = 1'b0;
            @(negedge clk);
        end
        fetch_valid = 1'b1;
        fetch       = build_packet(base);
        #1;
        accepted = fetch_ready;
        while (!accepted) begin
            @(negedge clk);
            #1;
            accepted = fetch_ready;
        end
        @(posedge clk);
    endtask

    // Fill the stalled pipeline, then flush everything in it
    task automatic run_flush_phase(input int base, input int lines);
        bit filled;
        int accepted;
        filled   = 1'b0;
        accepted = 0;
        @(negedge clk);
        fetch_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        pipe_mode = 2;
        @(negedge clk);
        for (int k = 0; k < lines && !filled; k++) begin
            @(negedge clk);
            fetch_valid = 1'b1;
            fetch       = build_packet(base + k * REC_W);
            #1;
            if (!fetch_ready) begin
                filled = 1'b1;
            end else begin
                accepted++;
                @(posedge clk);
            end
        end
        if (!filled) begin
            $display("Pipeline never filled up before the flush");
            stop_with_failure();
        end
        // Queue entries plus decode register, issue slot and skid entry
        if (accepted != FQ_DEPTH + 3) begin
            report_mismatch("packets taken before fetch_ready fell", accepted, FQ_DEPTH + 3);
        end
        @(negedge clk);
        fetch_valid = 1'b0;
        flush       = 1'b1;
        @(negedge clk);
        flush     = 1'b0;
        pipe_mode = 0;
    endtask

    always @(negedge clk) begin
        case (pipe_mode)
            0: pipe_ready <= 4'b1111;
            1: pipe_ready <= 4'($urandom);
            default: pipe_ready <= 4'b0000;
        endcase
    end

    // Monitor samples mid-cycle, after the falling-edge drive has settled
    initial begin
        id_ix_t exp;
        forever begin
            @(negedge clk);
            #2;
            if (i_rv_frontend.i_rv_frontend_checker.assertion_failures != 0) begin
                $display("A bound assertion on the DUT failed");
                stop_with_failure();
            end
            if (rst_n && !flush && (|(pipe_valid & pipe_ready))) begin
                if (exp_q.size() == 0) begin
                    $display("DUT issued an instruction that was not expected");
                    stop_with_failure();
                end
                exp = exp_q.pop_front();
                compare_pipe(exe_pipe_e'(pipe_valid), exp.exe_pipe);
                compare_issue(issue, exp);
                issued_count++;
            end
        end
    end

    initial begin
        longint limit;
        wait (stim_loaded);
        limit = (longint'(rec_count) * 200 + 2000) * CLK_PERIOD;
        #(limit);
        $display("Timeout, the run did not finish in time");
        stop_with_failure();
    end

    initial begin
        int base;
        int kind;
        int drain;
        void'($urandom(32'hca38));
        rst_n          = 1'b0;
        flush          = 1'b0;
        fetch_valid    = 1'b0;
        fetch          = '0;
        pipe_ready     = 4'b0000;
        pipe_mode      = 0;
        random_gaps    = 1'b0;
        expected_total = 0;
        issued_count   = 0;
        stim_loaded    = 1'b0;

        $readmemh("verification/rv_frontend_stimulus.txt", stim);
        rec_count = 0;
        while ((rec_count + 1) * REC_W <= STIM_WORDS && stim[rec_count * REC_W] !== 32'hf) begin
            rec_count++;
        end
        stim_loaded = 1'b1;

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        base = 0;
        while (base < rec_count * REC_W) begin
            kind = stim[base];
            case (kind)
                0: begin
                    if (stim[base + 4][27:24] != 4'b0000) begin
                        exp_q.push_back(build_expected(base));
                        expected_total++;
                    end
                    send_packet(base);
                    base += REC_W;
                end
                1: begin
                    pipe_mode   = stim[base + 1];
                    random_gaps = (stim[base + 1] == 1);
                    base += REC_W;
                end
                2: begin
                    run_flush_phase(base + REC_W, stim[base + 1]);
                    base += REC_W * (stim[base + 1] + 1);
                end
                default: begin
                    $display("Unknown record kind %0d in the stimulus file", kind);
                    stop_with_failure();
                end
            endcase
        end

        @(negedge clk);
        fetch_valid = 1'b0;
        pipe_mode   = 0;
        drain       = 0;
        while (exp_q.size() != 0 && drain < DRAIN_CYCLES) begin
            @(negedge clk);
            drain++;
        end
        repeat (10) @(negedge clk);

        if (exp_q.size() == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Issued %0d of %0d expected instructions",
                     issued_count, expected_total);
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire
